// ==== stepper_motion.f ====
verilog/motion_pkg.sv
verilog/word_decoder.sv
verilog/move_buffer.sv
verilog/dda_scheduler.sv
verilog/dda_axis.sv
verilog/reply_builder.sv
verilog/stepper_motion_top.sv
verif/stepper_motion_tb.sv

// ==== verif/stepper_motion_tb.sv ====
// Two motors only; move words and position replies assume the 2-axis message layout
module stepper_motion_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_MOTORS = 2;
  localparam int MAX_CYCLES = 20_000;  // Whole run needs well under a thousand cycles

  logic                    CLK;
  logic                    resetn;
  logic [63:0]             word_data_received;
  logic                    word_received;
  logic [63:0]             word_send_data;
  logic                    buffer_dtr;
  logic                    move_done;
  logic [NUM_MOTORS-1:0]   step;
  logic [NUM_MOTORS-1:0]   dir;
  logic [NUM_MOTORS-1:0]   enable;
  logic [NUM_MOTORS-1:0]   brake;

  int                      error_count = 0;
  int                      check_count = 0;
  int                      cycle_count = 0;
  int                      step_count [NUM_MOTORS];
  int                      done_count;
  logic [63:0]             replies [6];            // Reply after each move word
  logic signed [31:0]      exp_pos [NUM_MOTORS];   // Expected axis positions

  stepper_motion_top #(.num_motors(NUM_MOTORS), .default_clock_divisor(32))
    stepper_motion_top_inst (
    .CLK, .resetn, .word_data_received, .word_received, .word_send_data,
    .buffer_dtr, .move_done, .step, .dir, .enable, .brake
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Pulses seen at a clock edge were registered on the edge before
  always @(posedge CLK) begin
    cycle_count++;
    if (!resetn) begin
      for (int i = 0; i < NUM_MOTORS; i++) step_count[i] = step_count[i] + step[i];
      done_count = done_count + move_done;
    end
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never finished", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // Level held two cycles, then low two cycles
  task automatic send_word(input logic [63:0] data);
    word_data_received = data;
    word_received      = 1'b1;
    repeat (2) @(negedge CLK);
    word_received = 1'b0;
    repeat (2) @(negedge CLK);
  endtask

  task automatic send_move(input logic [1:0] move_dir, input logic [31:0] ticks,
                           input logic [63:0] inc0, input logic [63:0] inc_inc0,
                           input logic [63:0] inc1, input logic [63:0] inc_inc1);
    logic [63:0] words [6];
    words[0] = {8'h01, 54'd0, move_dir};
    words[1] = {32'd0, ticks};
    words[2] = inc0;
    words[3] = inc_inc0;
    words[4] = inc1;
    words[5] = inc_inc1;
    for (int w = 0; w < 6; w++) begin
      send_word(words[w]);
      replies[w] = word_send_data;
    end
  endtask

  task automatic clear_counts();
    for (int i = 0; i < NUM_MOTORS; i++) step_count[i] = 0;
    done_count = 0;
  endtask

  task automatic wait_for_done(input int target);
    while (done_count < target) @(negedge CLK);
  endtask

  // Carry count of a second-order accumulator over the given ticks
  function automatic int dda_steps(input int ticks, input logic [63:0] inc,
                                   input logic [63:0] inc_inc);
    logic [64:0] acc;
    logic [63:0] rate;
    int          count;
    acc   = '0;
    rate  = inc;
    count = 0;
    for (int t = 0; t < ticks; t++) begin
      acc = {1'b0, acc[63:0]} + {1'b0, rate};
      if (acc[64]) count++;
      rate = rate + inc_inc;  // Wraps as two's complement
    end
    return count;
  endfunction

  task automatic test_reset_and_info();
    check_value("enable", 0, enable);
    check_value("brake", 0, brake);
    check_value("step", 0, step);
    check_value("dir", 0, dir);
    check_value("move_done", 0, move_done);
    check_value("buffer_dtr", 1, buffer_dtr);
    check_value("word_send_data", 0, word_send_data);
    send_word({8'hfd, 56'd0});
    check_value("word_send_data", {40'd0, 8'd32, 8'd64, 8'd2}, word_send_data);
  endtask

  task automatic test_enable_brake();
    send_word({8'h0a, 54'd0, 2'b10});
    check_value("enable", 2'b10, enable);
    send_word({8'h0b, 54'd0, 2'b01});
    check_value("brake", 2'b01, brake);
    send_word({8'hfd, 56'd0});  // Leave a nonzero reply behind
    send_word({8'h77, 54'd0, 2'b11});
    check_value("word_send_data", 0, word_send_data);
    check_value("enable", 2'b10, enable);
    check_value("brake", 2'b01, brake);
  endtask

  task automatic test_constant_move();
    clear_counts();
    send_word({8'h20, 48'd0, 8'd4});
    send_move(2'b01, 16, 64'h8000_0000_0000_0000, 0, 64'h4000_0000_0000_0000, 0);
    check_value("dir", 2'b01, dir);
    wait_for_done(1);
    check_value("step_count[0]", 8, step_count[0]);
    check_value("step_count[1]", 4, step_count[1]);
    repeat (40) @(negedge CLK);
    check_value("done_count", 1, done_count);
    exp_pos[0] = 8;
    exp_pos[1] = -4;
  endtask

  task automatic test_position_readback();
    clear_counts();
    send_move(2'b00, 16, 64'h8000_0000_0000_0000, 0, 64'h4000_0000_0000_0000, 0);
    check_value("word_send_data", {32'd0, exp_pos[0]}, replies[1]);
    check_value("word_send_data", {32'd0, exp_pos[1]}, replies[3]);
    check_value("word_send_data", 0, replies[4]);
    wait_for_done(1);
    check_value("step_count[0]", 8, step_count[0]);
    check_value("step_count[1]", 4, step_count[1]);
    exp_pos[0] = exp_pos[0] - 8;
    exp_pos[1] = exp_pos[1] - 4;
  endtask

  task automatic test_buffering();
    logic [63:0] inc_a0;
    logic [63:0] ii_a0;
    logic [63:0] inc_a1;
    logic [63:0] ii_a1;
    logic [63:0] inc_b0;
    logic [63:0] inc_b1;
    logic [63:0] ii_b1;
    int          steps_a [NUM_MOTORS];
    int          steps_b [NUM_MOTORS];
    inc_a0 = 64'd1 << 60;
    ii_a0  = 64'd1 << 58;
    inc_a1 = 64'd1 << 63;
    ii_a1  = -(64'd1 << 57);  // Slowing down
    inc_b0 = (64'd1 << 63) + (64'd1 << 61);
    inc_b1 = 64'd1 << 61;
    ii_b1  = 64'd1 << 59;
    steps_a[0] = dda_steps(40, inc_a0, ii_a0);
    steps_a[1] = dda_steps(40, inc_a1, ii_a1);
    steps_b[0] = dda_steps(24, inc_b0, 0);
    steps_b[1] = dda_steps(24, inc_b1, ii_b1);
    clear_counts();
    send_move(2'b11, 40, inc_a0, ii_a0, inc_a1, ii_a1);
    check_value("word_send_data", {32'd0, exp_pos[0]}, replies[1]);
    check_value("word_send_data", {32'd0, exp_pos[1]}, replies[3]);
    check_value("buffer_dtr", 1, buffer_dtr);
    send_move(2'b10, 24, inc_b0, 0, inc_b1, ii_b1);
    check_value("buffer_dtr", 0, buffer_dtr);  // Both slots taken
    wait_for_done(1);
    check_value("buffer_dtr", 1, buffer_dtr);
    wait_for_done(2);
    repeat (20) @(negedge CLK);
    check_value("done_count", 2, done_count);
    check_value("step_count[0]", steps_a[0] + steps_b[0], step_count[0]);
    check_value("step_count[1]", steps_a[1] + steps_b[1], step_count[1]);
    exp_pos[0] = exp_pos[0] + steps_a[0] - steps_b[0];
    exp_pos[1] = exp_pos[1] + steps_a[1] + steps_b[1];
    send_move(2'b00, 1, 0, 0, 0, 0);  // Idle move, only reads positions back
    check_value("word_send_data", {32'd0, exp_pos[0]}, replies[1]);
    check_value("word_send_data", {32'd0, exp_pos[1]}, replies[3]);
    wait_for_done(3);
  endtask

  initial begin
    resetn             = 1'b1;
    word_received      = 1'b0;
    word_data_received = '0;
    clear_counts();
    repeat (5) @(negedge CLK);
    resetn = 1'b0;
    @(negedge CLK);
    test_reset_and_info();
    test_enable_brake();
    test_constant_move();
    test_position_readback();
    test_buffering();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/dda_axis.sv ====
// Second-order DDA for one axis; position wraps silently at 32 bits
module dda_axis (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic                                   dda_tick,
  input  logic                                   loading_move,
  input  logic                                   executing_move,
  input  motion_pkg::axis_motion_t               motion,
  input  logic                                   dir,
  output logic                                   step,
  output logic signed [motion_pkg::POS_BITS-1:0] position
);

  logic [motion_pkg::DDA_BITS-1:0] accumulator;
  logic [motion_pkg::DDA_BITS-1:0] increment;  // Current rate
  logic [motion_pkg::DDA_BITS:0]   sum;        // Top bit is the carry

  assign sum = {1'b0, accumulator} + {1'b0, increment};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accumulator <= '0;
      increment   <= '0;
      step        <= 1'b0;
      position    <= '0;
    end else begin
      step <= 1'b0;
      if (loading_move) begin
        accumulator <= '0;
        increment   <= motion.increment;
      end else if (dda_tick && executing_move) begin
        accumulator <= sum[motion_pkg::DDA_BITS-1:0];
        increment   <= increment + motion.increment_increment;  // Two's complement add
        step        <= sum[motion_pkg::DDA_BITS];
        if (sum[motion_pkg::DDA_BITS]) begin
          position <= dir ? position + 1 : position - 1;
        end
      end
    end
  end

endmodule

// ==== verilog/dda_scheduler.sv ====
// Ticks every divisor cycles, a zero divisor ticks every cycle; the next move starts one tick late
module dda_scheduler #(
  parameter int unsigned default_clock_divisor = 32
) (
  input  logic                                 CLK,
  input  logic                                 resetn,
  input  logic [motion_pkg::DIVISOR_BITS-1:0]  clock_divisor,
  input  logic                                 slot_ready,
  input  logic [motion_pkg::DURATION_BITS-1:0] duration,
  output logic                                 dda_tick,
  output logic                                 loading_move,
  output logic                                 executing_move,
  output logic                                 slot_release,
  output logic                                 move_done
);

  logic [motion_pkg::DIVISOR_BITS-1:0]  seen_divisor;  // Last decoder value
  logic [motion_pkg::DIVISOR_BITS-1:0]  divisor;
  logic [motion_pkg::DIVISOR_BITS-1:0]  div_count;
  logic [motion_pkg::DURATION_BITS-1:0] tick_count;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      seen_divisor   <= '0;
      divisor        <= default_clock_divisor[motion_pkg::DIVISOR_BITS-1:0];
      div_count      <= '0;
      dda_tick       <= 1'b0;
      loading_move   <= 1'b0;
      executing_move <= 1'b0;
      slot_release   <= 1'b0;
      move_done      <= 1'b0;
      tick_count     <= '0;
    end else begin
      // A divisor command shows up as a change on the decoder level
      seen_divisor <= clock_divisor;
      if (clock_divisor != seen_divisor) divisor <= clock_divisor;

      if (div_count == '0) begin
        dda_tick  <= 1'b1;
        div_count <= (divisor == '0) ? '0 : divisor - 1'b1;
      end else begin
        dda_tick  <= 1'b0;
        div_count <= div_count - 1'b1;
      end

      loading_move <= 1'b0;
      slot_release <= 1'b0;
      move_done    <= 1'b0;
      // Axes skip the tick that coincides with loading, so count it here too
      if (dda_tick && !loading_move) begin
        if (executing_move) begin
          if (tick_count + 1'b1 >= duration) begin
            move_done      <= 1'b1;
            slot_release   <= 1'b1;
            executing_move <= 1'b0;
          end else begin
            tick_count <= tick_count + 1'b1;
          end
        end else if (slot_ready && !slot_release) begin  // Old slot still marked full
          loading_move   <= 1'b1;
          executing_move <= 1'b1;
          tick_count     <= '0;
        end
      end
    end
  end

  a_slot_held : assert property (@(posedge CLK) disable iff (resetn)
    executing_move |-> slot_ready)
    else $error("running move lost its buffer slot");

endmodule

// ==== verilog/motion_pkg.sv ====
// Shared codes, widths and records; DDA width must equal the bus word width
package motion_pkg;

  localparam int WORD_BITS     = 64;
  localparam int MAX_MOTORS    = 8;   // Sizes the axis arrays in the records
  localparam int DDA_BITS      = 64;  // One data word per increment
  localparam int DURATION_BITS = 32;
  localparam int DIVISOR_BITS  = 8;
  localparam int POS_BITS      = 32;
  localparam int SLOTS         = 2;   // Move buffer depth

  // Header codes, bits 63:56 of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_MOTOR_BRAKE      = 8'h0b,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_CHANNEL_INFO     = 8'hfd
  } cmd_t;

  typedef struct packed {
    logic [DDA_BITS-1:0] increment;
    logic [DDA_BITS-1:0] increment_increment;  // Signed in use
  } axis_motion_t;

  // One buffer slot
  typedef struct packed {
    logic [MAX_MOTORS-1:0]         dir;
    logic [DURATION_BITS-1:0]      duration;  // In DDA ticks
    axis_motion_t [MAX_MOTORS-1:0] axis;
  } move_t;

  typedef struct packed {
    logic [MAX_MOTORS-1:0] enable;
    logic [MAX_MOTORS-1:0] brake;
  } drive_ctrl_t;

endpackage

// ==== verilog/move_buffer.sv ====
// Two slots; a write while both are full is a host error and is dropped
module move_buffer (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              move_write,
  input  motion_pkg::move_t move,
  input  logic              slot_release,
  output logic              slot_ready,
  output motion_pkg::move_t active_move,
  output logic              buffer_dtr
);

  localparam int IDX_BITS = $clog2(motion_pkg::SLOTS);

  motion_pkg::move_t            slots [motion_pkg::SLOTS];
  logic [IDX_BITS-1:0]          wr_idx;
  logic [IDX_BITS-1:0]          rd_idx;
  logic [motion_pkg::SLOTS-1:0] wr_toggle;
  logic [motion_pkg::SLOTS-1:0] rd_toggle;
  logic [motion_pkg::SLOTS-1:0] full;

  assign full        = wr_toggle ^ rd_toggle;  // Slot full when its toggles differ
  assign slot_ready  = full[rd_idx];
  assign buffer_dtr  = ~&full;
  assign active_move = slots[rd_idx];

  always_ff @(posedge CLK) begin
    if (move_write && !full[wr_idx]) slots[wr_idx] <= move;
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_idx    <= '0;
      rd_idx    <= '0;
      wr_toggle <= '0;
      rd_toggle <= '0;
    end else begin
      if (move_write && !full[wr_idx]) begin
        wr_toggle[wr_idx] <= ~wr_toggle[wr_idx];
        wr_idx            <= wr_idx + 1'b1;
      end
      if (slot_release && slot_ready) begin
        rd_toggle[rd_idx] <= ~rd_toggle[rd_idx];
        rd_idx            <= rd_idx + 1'b1;
      end
    end
  end

  a_no_overflow : assert property (@(posedge CLK) disable iff (resetn)
    move_write |-> !(&full))
    else $error("move written while both slots are full");

endmodule

// ==== verilog/reply_builder.sv ====
// Position replies come from the snapshot taken at the move header, not live counters
module reply_builder #(
  parameter int num_motors = 2
) (
  input  logic                                                   CLK,
  input  logic                                                   resetn,
  input  logic [motion_pkg::MAX_MOTORS-1:0][motion_pkg::POS_BITS-1:0] positions,
  input  logic                                                   snapshot,
  input  logic [2:0]                                             reply_axis,
  input  logic                                                   reply_axis_valid,
  input  logic                                                   info_request,
  input  logic                                                   word_start,
  output logic [motion_pkg::WORD_BITS-1:0]                       word_send_data
);

  logic [motion_pkg::MAX_MOTORS-1:0][motion_pkg::POS_BITS-1:0] stored;

  always_ff @(posedge CLK) begin
    if (snapshot) stored <= positions;
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_send_data <= '0;
    end else if (info_request) begin
      // Motors, DDA width, duration width
      word_send_data <= {40'd0, 8'(motion_pkg::DURATION_BITS), 8'(motion_pkg::DDA_BITS),
                         8'(num_motors)};
    end else if (reply_axis_valid) begin
      word_send_data <= {32'd0, stored[reply_axis]};
    end else if (word_start) begin
      word_send_data <= '0;
    end
  end

endmodule

// ==== verilog/stepper_motion_top.sv ====
// num_motors from 1 to 8; word_received is a level and move_done a one-cycle pulse
module stepper_motion_top #(
  parameter int num_motors            = 2,
  parameter int default_clock_divisor = 32
) (
  input  logic                             CLK,
  input  logic                             resetn,
  input  logic [motion_pkg::WORD_BITS-1:0] word_data_received,
  input  logic                             word_received,
  output logic [motion_pkg::WORD_BITS-1:0] word_send_data,
  output logic                             buffer_dtr,
  output logic                             move_done,
  output logic [num_motors-1:0]            step,
  output logic [num_motors-1:0]            dir,
  output logic [num_motors-1:0]            enable,
  output logic [num_motors-1:0]            brake
);

  logic                                                        move_write;
  motion_pkg::move_t                                           new_move;
  motion_pkg::move_t                                           active_move;
  motion_pkg::drive_ctrl_t                                     drive_ctrl;
  logic [motion_pkg::DIVISOR_BITS-1:0]                         clock_divisor;
  logic                                                        snapshot;
  logic [2:0]                                                  reply_axis;
  logic                                                        reply_axis_valid;
  logic                                                        info_request;
  logic                                                        word_start;
  logic                                                        slot_ready;
  logic                                                        slot_release;
  logic                                                        dda_tick;
  logic                                                        loading_move;
  logic                                                        executing_move;
  logic [motion_pkg::MAX_MOTORS-1:0][motion_pkg::POS_BITS-1:0] positions;

  assign dir    = active_move.dir[num_motors-1:0] & {num_motors{slot_ready}};  // Low when idle
  assign enable = drive_ctrl.enable[num_motors-1:0];
  assign brake  = drive_ctrl.brake[num_motors-1:0];

  word_decoder #(.num_motors(num_motors)) word_decoder_inst (
    .CLK, .resetn, .word_data_received, .word_received,
    .move_write, .move(new_move), .drive_ctrl, .clock_divisor,
    .snapshot, .reply_axis, .reply_axis_valid, .info_request, .word_start
  );

  move_buffer move_buffer_inst (
    .CLK, .resetn, .move_write, .move(new_move), .slot_release,
    .slot_ready, .active_move, .buffer_dtr
  );

  dda_scheduler #(.default_clock_divisor(default_clock_divisor)) dda_scheduler_inst (
    .CLK, .resetn, .clock_divisor, .slot_ready, .duration(active_move.duration),
    .dda_tick, .loading_move, .executing_move, .slot_release, .move_done
  );

  for (genvar i = 0; i < motion_pkg::MAX_MOTORS; i++) begin : g_axis
    if (i < num_motors) begin : g_used
      dda_axis dda_axis_inst (
        .CLK, .resetn, .dda_tick, .loading_move, .executing_move,
        .motion(active_move.axis[i]), .dir(dir[i]),
        .step(step[i]), .position(positions[i])
      );
    end else begin : g_unused
      assign positions[i] = '0;
    end
  end

  reply_builder #(.num_motors(num_motors)) reply_builder_inst (
    .CLK, .resetn, .positions, .snapshot, .reply_axis, .reply_axis_valid,
    .info_request, .word_start, .word_send_data
  );

endmodule

// ==== verilog/word_decoder.sv ====
// Reacts only to rising edges of word_received; a move message cannot be aborted once opened
module word_decoder #(
  parameter int num_motors = 2
) (
  input  logic                                 CLK,
  input  logic                                 resetn,
  input  logic [motion_pkg::WORD_BITS-1:0]     word_data_received,
  input  logic                                 word_received,
  output logic                                 move_write,
  output motion_pkg::move_t                    move,
  output motion_pkg::drive_ctrl_t              drive_ctrl,
  output logic [motion_pkg::DIVISOR_BITS-1:0]  clock_divisor,
  output logic                                 snapshot,
  output logic [2:0]                           reply_axis,
  output logic                                 reply_axis_valid,
  output logic                                 info_request,
  output logic                                 word_start
);

  // Header plus duration plus two words per axis
  localparam logic [7:0] LAST_WORD = 8'(2 * num_motors + 1);
  localparam logic [motion_pkg::MAX_MOTORS-1:0] MOTOR_MASK =
    {motion_pkg::MAX_MOTORS{1'b1}} >> (motion_pkg::MAX_MOTORS - num_motors);

  logic              received_q;
  logic              move_open;   // Move header seen, data words pending
  logic [7:0]        word_count;  // Words of the open message so far
  logic              accept;
  motion_pkg::cmd_t  header;

  assign accept = word_received & ~received_q;
  assign header = motion_pkg::cmd_t'(word_data_received[motion_pkg::WORD_BITS-1 -: 8]);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      received_q       <= 1'b0;
      move_open        <= 1'b0;
      word_count       <= '0;
      move_write       <= 1'b0;
      drive_ctrl       <= '0;
      clock_divisor    <= '0;  // Scheduler keeps its own default until a divisor command
      snapshot         <= 1'b0;
      reply_axis       <= '0;
      reply_axis_valid <= 1'b0;
      info_request     <= 1'b0;
      word_start       <= 1'b0;
    end else begin
      received_q       <= word_received;
      move_write       <= 1'b0;
      snapshot         <= 1'b0;
      reply_axis_valid <= 1'b0;
      info_request     <= 1'b0;
      word_start       <= accept;
      if (accept && !move_open) begin
        case (header)
          motion_pkg::CMD_COORDINATED_STEP: begin
            move_open  <= 1'b1;
            word_count <= 8'd1;
            snapshot   <= 1'b1;
          end
          motion_pkg::CMD_MOTOR_ENABLE:
            drive_ctrl.enable <= word_data_received[motion_pkg::MAX_MOTORS-1:0] & MOTOR_MASK;
          motion_pkg::CMD_MOTOR_BRAKE:
            drive_ctrl.brake <= word_data_received[motion_pkg::MAX_MOTORS-1:0] & MOTOR_MASK;
          motion_pkg::CMD_CLK_DIVISOR:
            clock_divisor <= word_data_received[motion_pkg::DIVISOR_BITS-1:0];
          motion_pkg::CMD_CHANNEL_INFO:
            info_request <= 1'b1;
          default: ;  // Unknown header, reply is cleared by word_start
        endcase
      end else if (accept) begin
        word_count <= word_count + 1'b1;
        if (word_count == 8'd1) begin  // Duration word returns axis 0
          reply_axis       <= '0;
          reply_axis_valid <= 1'b1;
        end
        for (int k = 0; k < num_motors - 1; k++) begin
          if (word_count == 8'(2 * k + 3)) begin
            reply_axis       <= 3'(k + 1);
            reply_axis_valid <= 1'b1;
          end
        end
        if (word_count == LAST_WORD) begin
          move_open  <= 1'b0;
          word_count <= '0;
          move_write <= 1'b1;
        end
      end
    end
  end

  // Move record under construction
  always_ff @(posedge CLK) begin
    if (accept && !move_open && header == motion_pkg::CMD_COORDINATED_STEP) begin
      move.dir <= word_data_received[motion_pkg::MAX_MOTORS-1:0] & MOTOR_MASK;
    end
    if (accept && move_open) begin
      if (word_count == 8'd1) begin
        move.duration <= word_data_received[motion_pkg::DURATION_BITS-1:0];
      end
      for (int k = 0; k < num_motors; k++) begin
        if (word_count == 8'(2 * k + 2)) move.axis[k].increment <= word_data_received;
        if (word_count == 8'(2 * k + 3)) move.axis[k].increment_increment <= word_data_received;
      end
    end
  end

  a_word_count : assert property (@(posedge CLK) disable iff (resetn)
    word_count <= LAST_WORD)
    else $error("move message word count overran");

endmodule
